//--- source/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

    // ========================================
    // binary32 layout
    // ========================================

    localparam int word_width = 32;
    localparam int exp_width = 8;
    localparam int frac_width = 23;
    localparam int sig_width = frac_width + 1;  // hidden one included
    localparam int exp_bias = 127;

    typedef struct packed {
        logic                  sign;
        logic [exp_width-1:0]  exponent;
        logic [frac_width-1:0] fraction;
    } float_fields;

    // ========================================
    // operand word
    // ========================================

    // same 32 bits seen as a float or as a two's complement integer
    typedef union packed {
        float_fields                  f;
        logic signed [word_width-1:0] i;
    } operand_word;

endpackage

`default_nettype wire

//--- source/fpu_op_pkg.sv
`default_nettype none

package fpu_op_pkg;

    localparam int op_width = 3;

    // operation codes, 5..7 reserved
    localparam logic [op_width-1:0] op_add = 3'd0;
    localparam logic [op_width-1:0] op_sub = 3'd1;
    localparam logic [op_width-1:0] op_mul = 3'd2;
    localparam logic [op_width-1:0] op_itof = 3'd3;
    localparam logic [op_width-1:0] op_ftoi = 3'd4;

    // multiplier digit slicing
    localparam int digit_bits = 12;
    localparam int digit_count =
        (fp_format_pkg::sig_width + digit_bits - 1) / digit_bits;

endpackage

`default_nettype wire

//--- source/fp_addsub.sv
`timescale 1ns/1ps
`default_nettype none

module fp_addsub (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        go,
    input  wire                        subtract,
    input  wire fp_format_pkg::operand_word a,
    input  wire fp_format_pkg::operand_word b,
    output fp_format_pkg::operand_word sum,
    output logic                       finish
);

    fp_format_pkg::operand_word opa;
    fp_format_pkg::operand_word opb;
    logic [fp_format_pkg::sig_width-1:0] sig_a;
    logic [fp_format_pkg::sig_width-1:0] sig_b;
    logic [fp_format_pkg::sig_width-1:0] al_a;
    logic [fp_format_pkg::sig_width-1:0] al_b;
    logic [fp_format_pkg::sig_width:0] mag;  // one carry bit on top
    logic [fp_format_pkg::exp_width-1:0] exp_r;
    logic sum_sign;
    logic eff_sub;
    logic align_q;
    logic sign_q;
    logic sum_q;
    logic norm_q;
    logic norm_done;

    assign sig_a = (opa.f.exponent == '0) ? '0 : {1'b1, opa.f.fraction};
    assign sig_b = (opb.f.exponent == '0) ? '0 : {1'b1, opb.f.fraction};

    // carry, zero or leading one in place ends normalisation
    assign norm_done = norm_q & (mag[fp_format_pkg::sig_width] | (mag == '0)
                                 | mag[fp_format_pkg::sig_width-1]);

    // ========================================
    // stage sequencing
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            align_q <= 1'b0;
            sign_q <= 1'b0;
            sum_q <= 1'b0;
            norm_q <= 1'b0;
            finish <= 1'b0;
        end else begin
            align_q <= go;
            sign_q <= align_q;
            sum_q <= sign_q;
            norm_q <= sum_q | (norm_q & ~norm_done);
            finish <= norm_done;
        end
    end

    // ========================================
    // datapath
    // ========================================

    always_ff @(posedge clk) begin
        if (go) begin
            opa <= a;
            opb <= {b.f.sign ^ subtract, b[fp_format_pkg::word_width-2:0]};  // sub flips b
        end
        if (align_q) begin
            if (opa.f.exponent >= opb.f.exponent) begin
                al_a <= sig_a;
                al_b <= sig_b >> (opa.f.exponent - opb.f.exponent);
                exp_r <= opa.f.exponent;
            end else begin
                al_a <= sig_a >> (opb.f.exponent - opa.f.exponent);
                al_b <= sig_b;
                exp_r <= opb.f.exponent;
            end
        end
        if (sign_q) begin
            eff_sub <= opa.f.sign ^ opb.f.sign;
            if (al_a >= al_b) begin
                sum_sign <= opa.f.sign;
            end else begin
                al_a <= al_b;  // larger magnitude first
                al_b <= al_a;
                sum_sign <= opb.f.sign;
            end
        end
        if (sum_q) begin
            mag <= eff_sub ? {1'b0, al_a} - {1'b0, al_b} : {1'b0, al_a} + {1'b0, al_b};
        end
        if (norm_q) begin
            if (mag[fp_format_pkg::sig_width]) begin
                sum <= {sum_sign, exp_r + 1'b1, mag[fp_format_pkg::sig_width-1:1]};
            end else if (mag == '0) begin
                sum <= '0;  // exact cancel gives +0
            end else if (mag[fp_format_pkg::sig_width-1]) begin
                sum <= {sum_sign, exp_r, mag[fp_format_pkg::frac_width-1:0]};
            end else begin
                mag <= mag << 1;
                exp_r <= exp_r - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/digit_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module digit_multiplier (
    input  wire                                    clk,
    input  wire                                    rst,
    input  wire                                    go,
    input  wire [fp_format_pkg::sig_width-1:0]     x,
    input  wire [fp_format_pkg::sig_width-1:0]     y,
    output logic [2*fp_format_pkg::sig_width-1:0]  product,
    output logic                                   finish
);

    // factors padded out to whole digits
    logic [fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] xr;
    logic [fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] yr;
    logic [fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] xs;
    logic [fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] ys;
    logic [2*fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] acc;
    logic [2*fpu_op_pkg::digit_count*fpu_op_pkg::digit_bits-1:0] partial;
    logic [fpu_op_pkg::digit_bits-1:0] xd;
    logic [fpu_op_pkg::digit_bits-1:0] yd;
    logic [2*fpu_op_pkg::digit_bits-1:0] dprod;
    logic [$clog2(fpu_op_pkg::digit_count*fpu_op_pkg::digit_count+1)-1:0] step;
    logic [$clog2(fpu_op_pkg::digit_count*fpu_op_pkg::digit_count+1)-1:0] idx;
    logic running;

    // pair 0 is taken straight from the inputs on go
    always_comb begin
        xs = xr;
        ys = yr;
        idx = step;
        if (go) begin
            xs = '0;
            ys = '0;
            xs[fp_format_pkg::sig_width-1:0] = x;
            ys[fp_format_pkg::sig_width-1:0] = y;
            idx = '0;
        end
        xd = xs[(idx % fpu_op_pkg::digit_count) * fpu_op_pkg::digit_bits +: fpu_op_pkg::digit_bits];
        yd = ys[(idx / fpu_op_pkg::digit_count) * fpu_op_pkg::digit_bits +: fpu_op_pkg::digit_bits];
        dprod = xd * yd;
        partial = '0;
        partial[2*fpu_op_pkg::digit_bits-1:0] = dprod;
        partial = partial << (((idx % fpu_op_pkg::digit_count) + (idx / fpu_op_pkg::digit_count))
                              * fpu_op_pkg::digit_bits);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            step <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (go) begin
                step <= 1'b1;
                running <= (fpu_op_pkg::digit_count > 1);
                finish <= (fpu_op_pkg::digit_count == 1);
            end else if (running) begin
                step <= step + 1'b1;
                if (int'(step) == fpu_op_pkg::digit_count * fpu_op_pkg::digit_count - 1) begin
                    running <= 1'b0;  // last pair
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            xr <= xs;
            yr <= ys;
            acc <= partial;
        end else if (running) begin
            acc <= acc + partial;
        end
    end

    assign product = acc[2*fp_format_pkg::sig_width-1:0];

endmodule

`default_nettype wire

//--- source/fp_mul.sv
`timescale 1ns/1ps
`default_nettype none

module fp_mul (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        go,
    input  wire fp_format_pkg::operand_word a,
    input  wire fp_format_pkg::operand_word b,
    output fp_format_pkg::operand_word product,
    output logic                       finish
);

    fp_format_pkg::operand_word opa;
    fp_format_pkg::operand_word opb;
    logic [fp_format_pkg::sig_width-1:0] sig_a;
    logic [fp_format_pkg::sig_width-1:0] sig_b;
    logic [2*fp_format_pkg::sig_width-1:0] mul_product;
    logic [2*fp_format_pkg::sig_width-1:0] prod_r;
    logic [fp_format_pkg::exp_width-1:0] exp_r;
    logic [fp_format_pkg::frac_width-1:0] frac_r;
    logic sign_r;
    logic zero_r;
    logic mul_finish;
    logic launch_q;
    logic wait_q;
    logic norm_q;
    logic emit_q;

    assign sig_a = (opa.f.exponent == '0) ? '0 : {1'b1, opa.f.fraction};
    assign sig_b = (opb.f.exponent == '0) ? '0 : {1'b1, opb.f.fraction};

    digit_multiplier u_digit_multiplier (
        .clk     (clk),
        .rst     (rst),
        .go      (launch_q),
        .x       (sig_a),
        .y       (sig_b),
        .product (mul_product),
        .finish  (mul_finish)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            launch_q <= 1'b0;
            wait_q <= 1'b0;
            norm_q <= 1'b0;
            emit_q <= 1'b0;
            finish <= 1'b0;
        end else begin
            launch_q <= go;
            wait_q <= launch_q | (wait_q & ~mul_finish);
            norm_q <= wait_q & mul_finish;
            emit_q <= norm_q;
            finish <= emit_q;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            opa <= a;
            opb <= b;
        end
        if (launch_q) begin
            sign_r <= opa.f.sign ^ opb.f.sign;
            exp_r <= fp_format_pkg::exp_width'(opa.f.exponent + opb.f.exponent
                                                - fp_format_pkg::exp_bias);
            zero_r <= (opa.f.exponent == '0) || (opb.f.exponent == '0);
        end
        if (wait_q && mul_finish) begin
            prod_r <= mul_product;
        end
        if (norm_q) begin
            if (prod_r[2*fp_format_pkg::sig_width-1]) begin  // product in [2,4)
                frac_r <= prod_r[2*fp_format_pkg::sig_width-2 -: fp_format_pkg::frac_width];
                exp_r <= exp_r + 1'b1;
            end else begin
                frac_r <= prod_r[2*fp_format_pkg::sig_width-3 -: fp_format_pkg::frac_width];
            end
        end
        if (emit_q) begin
            product <= zero_r ? '0 : {sign_r, exp_r, frac_r};
        end
    end

endmodule

`default_nettype wire

//--- source/fp_convert.sv
`timescale 1ns/1ps
`default_nettype none

module fp_convert (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        go,
    input  wire                        to_float,
    input  wire fp_format_pkg::operand_word a,
    output fp_format_pkg::operand_word converted,
    output logic                       finish
);

    logic [fp_format_pkg::word_width-1:0] mag;
    logic [$clog2(fp_format_pkg::word_width)-1:0] lead;
    logic [fp_format_pkg::word_width-1:0] norm;
    logic [fp_format_pkg::word_width-1:0] sig;
    logic [fp_format_pkg::word_width-1:0] whole;
    logic [fp_format_pkg::exp_width-1:0] shift;
    fp_format_pkg::operand_word itof_word;
    fp_format_pkg::operand_word ftoi_word;

    // ========================================
    // integer to float
    // ========================================

    always_comb begin
        mag = a.i[fp_format_pkg::word_width-1] ? -a.i : a.i;
        lead = '0;
        for (int k = 0; k < fp_format_pkg::word_width; k++) begin
            if (mag[k]) begin
                lead = k[$clog2(fp_format_pkg::word_width)-1:0];  // highest set bit wins
            end
        end
        if (lead <= fp_format_pkg::frac_width) begin
            norm = mag << (fp_format_pkg::frac_width - lead);
        end else begin
            norm = mag >> (lead - fp_format_pkg::frac_width);  // low bits dropped
        end
        itof_word.f.sign = a.i[fp_format_pkg::word_width-1];
        itof_word.f.exponent = fp_format_pkg::exp_width'(fp_format_pkg::exp_bias + lead);
        itof_word.f.fraction = norm[fp_format_pkg::frac_width-1:0];
        if (mag == '0) begin
            itof_word = '0;
        end
    end

    // ========================================
    // float to integer
    // ========================================

    always_comb begin
        sig = fp_format_pkg::word_width'({1'b1, a.f.fraction});
        shift = fp_format_pkg::exp_width'(a.f.exponent - fp_format_pkg::exp_bias);
        if (a.f.exponent < fp_format_pkg::exp_bias) begin
            whole = '0;  // |x| < 1
        end else if (shift <= fp_format_pkg::frac_width) begin
            whole = sig >> (fp_format_pkg::frac_width - shift);
        end else begin
            whole = sig << (shift - fp_format_pkg::frac_width);
        end
        ftoi_word.i = a.f.sign ? -whole : whole;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            finish <= 1'b0;
        end else begin
            finish <= go;
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            converted <= to_float ? itof_word : ftoi_word;
        end
    end

endmodule

`default_nettype wire

//--- source/fp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fp_unit (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             start,
    input  wire [fpu_op_pkg::op_width-1:0]  op,
    input  wire fp_format_pkg::operand_word a,
    input  wire fp_format_pkg::operand_word b,
    output fp_format_pkg::operand_word      result,
    output logic                            busy,
    output logic                            done
);

    logic [fpu_op_pkg::op_width-1:0] op_r;
    fp_format_pkg::operand_word a_r;
    fp_format_pkg::operand_word b_r;
    fp_format_pkg::operand_word sum;
    fp_format_pkg::operand_word prod;
    fp_format_pkg::operand_word conv;
    fp_format_pkg::operand_word result_q;
    logic busy_q;
    logic go_q;
    logic op_known;
    logic accept;
    logic add_go;
    logic mul_go;
    logic cvt_go;
    logic add_fin;
    logic mul_fin;
    logic cvt_fin;

    // ========================================
    // dispatch
    // ========================================

    assign op_known = (op == fpu_op_pkg::op_add) || (op == fpu_op_pkg::op_sub)
                      || (op == fpu_op_pkg::op_mul) || (op == fpu_op_pkg::op_itof)
                      || (op == fpu_op_pkg::op_ftoi);
    assign accept = start & ~busy & op_known;

    assign add_go = go_q & ((op_r == fpu_op_pkg::op_add) | (op_r == fpu_op_pkg::op_sub));
    assign mul_go = go_q & (op_r == fpu_op_pkg::op_mul);
    assign cvt_go = go_q & ((op_r == fpu_op_pkg::op_itof) | (op_r == fpu_op_pkg::op_ftoi));

    always_ff @(posedge clk) begin
        if (accept) begin
            op_r <= op;
            a_r <= a;
            b_r <= b;
        end
    end

    fp_addsub u_addsub (
        .clk      (clk),
        .rst      (rst),
        .go       (add_go),
        .subtract (op_r == fpu_op_pkg::op_sub),
        .a        (a_r),
        .b        (b_r),
        .sum      (sum),
        .finish   (add_fin)
    );

    fp_mul u_mul (
        .clk     (clk),
        .rst     (rst),
        .go      (mul_go),
        .a       (a_r),
        .b       (b_r),
        .product (prod),
        .finish  (mul_fin)
    );

    fp_convert u_convert (
        .clk       (clk),
        .rst       (rst),
        .go        (cvt_go),
        .to_float  (op_r == fpu_op_pkg::op_itof),
        .a         (a_r),
        .converted (conv),
        .finish    (cvt_fin)
    );

    // ========================================
    // completion
    // ========================================

    assign done = add_fin | mul_fin | cvt_fin;
    assign busy = busy_q & ~done;  // free again in the done cycle

    always_comb begin
        if (add_fin) begin
            result = sum;
        end else if (mul_fin) begin
            result = prod;
        end else if (cvt_fin) begin
            result = conv;
        end else begin
            result = result_q;  // hold last answer
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            go_q <= 1'b0;
            result_q <= '0;
        end else begin
            go_q <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done) begin
                busy_q <= 1'b0;
            end
            if (done) begin
                result_q <= result;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/fp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fp_checker (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            start,
    input  wire [fpu_op_pkg::op_width-1:0] op,
    input  wire fp_format_pkg::operand_word a,
    input  wire fp_format_pkg::operand_word b,
    input  wire fp_format_pkg::operand_word result,
    input  wire                            busy,
    input  wire                            done,
    output int                             error_count,
    output int                             check_count
);

    logic [fpu_op_pkg::op_width-1:0] op_q;
    logic [31:0] a_q;
    logic [31:0] b_q;
    logic [31:0] expected;
    logic [31:0] last_result;
    logic pending;
    int cycles;

    // ========================================
    // reference model
    // ========================================

    function automatic logic [fp_format_pkg::sig_width-1:0] sig_of(
        input fp_format_pkg::operand_word x);
        return (x.f.exponent == '0) ? '0 : {1'b1, x.f.fraction};
    endfunction

    function automatic logic [31:0] model_add(input fp_format_pkg::operand_word x,
                                              input fp_format_pkg::operand_word y,
                                              input logic sub);
        logic [24:0] sx;
        logic [24:0] sy;
        logic [24:0] mag;
        logic sign_y;
        logic sign_r;
        int e;
        sign_y = y.f.sign ^ sub;
        sx = {1'b0, sig_of(x)};
        sy = {1'b0, sig_of(y)};
        if (x.f.exponent >= y.f.exponent) begin
            e = int'(x.f.exponent);
            sy = sy >> (x.f.exponent - y.f.exponent);
        end else begin
            e = int'(y.f.exponent);
            sx = sx >> (y.f.exponent - x.f.exponent);
        end
        sign_r = (sx >= sy) ? x.f.sign : sign_y;  // larger magnitude decides
        if (x.f.sign != sign_y) begin
            mag = (sx >= sy) ? sx - sy : sy - sx;
        end else begin
            mag = sx + sy;
        end
        if (mag == '0) begin
            return 32'd0;
        end
        if (mag[24]) begin
            mag = mag >> 1;  // lsb dropped
            e = e + 1;
        end
        while (!mag[23]) begin
            mag = mag << 1;
            e = e - 1;
        end
        return {sign_r, 8'(e), mag[22:0]};
    endfunction

    function automatic logic [31:0] model_mul(input fp_format_pkg::operand_word x,
                                              input fp_format_pkg::operand_word y);
        logic [47:0] p;
        logic sign_r;
        int e;
        if (x.f.exponent == '0 || y.f.exponent == '0) begin
            return 32'd0;
        end
        p = sig_of(x) * sig_of(y);
        sign_r = x.f.sign ^ y.f.sign;
        e = int'(x.f.exponent) + int'(y.f.exponent) - fp_format_pkg::exp_bias;
        if (p[47]) begin
            return {sign_r, 8'(e + 1), p[46:24]};
        end
        return {sign_r, 8'(e), p[45:23]};
    endfunction

    function automatic logic [31:0] model_itof(input fp_format_pkg::operand_word x);
        logic [31:0] mag;
        logic neg;
        int lead;
        if (x.i == 0) begin
            return 32'd0;
        end
        neg = (x.i < 0);
        mag = neg ? 32'(-x.i) : 32'(x.i);
        lead = 31;
        while (!mag[lead]) begin
            lead = lead - 1;
        end
        mag = mag << (31 - lead);  // leading one up to bit 31
        return {neg, 8'(fp_format_pkg::exp_bias + lead), mag[30:8]};
    endfunction

    function automatic logic [31:0] model_ftoi(input fp_format_pkg::operand_word x);
        logic [55:0] whole;
        int s;
        if (int'(x.f.exponent) < fp_format_pkg::exp_bias) begin
            return 32'd0;
        end
        s = int'(x.f.exponent) - fp_format_pkg::exp_bias;
        // scale 1.fraction by 2^s, then drop the fraction bits
        whole = 56'({1'b1, x.f.fraction}) << s;
        whole = whole >> fp_format_pkg::frac_width;
        return x.f.sign ? -whole[31:0] : whole[31:0];
    endfunction

    // ========================================
    // port watcher
    // ========================================

    always @(posedge clk) begin
        if (rst) begin
            pending = 1'b0;
            cycles = 0;
            last_result = '0;
            error_count = 0;
            check_count = 0;
        end else begin
            cycles = cycles + 1;
            if (done) begin
                if (!pending) begin
                    $display("done raised with no operation pending, result %08h", result);
                    error_count++;
                end else begin
                    check_count++;
                    if (result !== expected) begin
                        $display("FAIL result: expected %08h, actual %08h (op %0d a %08h b %08h)",
                                 expected, result, op_q, a_q, b_q);
                        error_count++;
                    end
                    if ((op_q == fpu_op_pkg::op_itof || op_q == fpu_op_pkg::op_ftoi)
                        && cycles != 2) begin
                        $display("conversion finished %0d cycles after start instead of 2",
                                 cycles);
                        error_count++;
                    end
                end
                pending = 1'b0;
                last_result = result;
            end else begin
                if (result !== last_result) begin
                    $display("FAIL result: expected %08h (held), actual %08h",
                             last_result, result);
                    error_count++;
                end
                if (busy !== pending) begin
                    $display("FAIL busy: expected %h, actual %h", pending, busy);
                    error_count++;
                end
            end
            if (start && !pending) begin
                pending = 1'b1;
                cycles = 0;
                op_q = op;
                a_q = a;
                b_q = b;
                case (op)
                    fpu_op_pkg::op_add: expected = model_add(a, b, 1'b0);
                    fpu_op_pkg::op_sub: expected = model_add(a, b, 1'b1);
                    fpu_op_pkg::op_mul: expected = model_mul(a, b);
                    fpu_op_pkg::op_itof: expected = model_itof(a);
                    fpu_op_pkg::op_ftoi: expected = model_ftoi(a);
                    default: pending = 1'b0;  // reserved codes are ignored
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_fp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fp_unit;

    logic clk;
    logic rst;
    logic start;
    logic [fpu_op_pkg::op_width-1:0] op;
    fp_format_pkg::operand_word a;
    fp_format_pkg::operand_word b;
    fp_format_pkg::operand_word result;
    logic busy;
    logic done;
    int error_count;
    int check_count;
    int timeouts;
    int test_base;
    logic [31:0] lfsr;

    fp_unit u_fp_unit (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    fp_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .op          (op),
        .a           (a),
        .b           (b),
        .result      (result),
        .busy        (busy),
        .done        (done),
        .error_count (error_count),
        .check_count (check_count)
    );

    always #10 clk = ~clk;

    // ========================================
    // random source
    // ========================================

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_float(input int exp_lo, input int exp_span,
                              output fp_format_pkg::operand_word w);
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] f;
        take_bits(1, s);
        take_bits(6, e);
        take_bits(23, f);
        w.f.sign = s[0];
        w.f.exponent = 8'(exp_lo + int'(e % exp_span));
        w.f.fraction = f[22:0];
    endtask

    task automatic rand_int(output fp_format_pkg::operand_word w);
        logic [31:0] s;
        logic [31:0] width;
        logic [31:0] m;
        take_bits(1, s);
        take_bits(5, width);
        take_bits(int'(width % 30) + 1, m);  // 1..30 bit magnitude
        w.i = s[0] ? -$signed(m) : $signed(m);
    endtask

    // ========================================
    // handshake
    // ========================================

    task automatic wait_done();
        for (int n = 0; n < 200; n++) begin
            @(negedge clk);
            if (done === 1'b1) begin
                return;
            end
        end
        $display("timeout: no done within 200 cycles, op %0d", op);
        timeouts = timeouts + 1;
    endtask

    task automatic run_op(input logic [fpu_op_pkg::op_width-1:0] code,
                          input fp_format_pkg::operand_word x,
                          input fp_format_pkg::operand_word y);
        @(negedge clk);
        start = 1'b1;
        op = code;
        a = x;
        b = y;
        @(negedge clk);
        start = 1'b0;
        wait_done();
    endtask

    task automatic report_test(input string name, input int ops);
        @(negedge clk);  // let the last compare land
        $display("test %s: %0d ops, %0d errors", name, ops,
                 error_count + timeouts - test_base);
        test_base = error_count + timeouts;
    endtask

    initial begin
        fp_format_pkg::operand_word x;
        fp_format_pkg::operand_word y;
        int n;
        clk = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        op = '0;
        a = '0;
        b = '0;
        lfsr = 32'h4cd25735;
        timeouts = 0;
        test_base = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        repeat (4) @(negedge clk);
        report_test("reset", 0);

        for (n = 0; n < 300; n++) begin
            rand_float(100, 55, x);
            rand_float(100, 55, y);
            if (n % 10 == 9) begin
                y = x;
                y.f.sign = ~x.f.sign;  // exact cancel
            end
            run_op(fpu_op_pkg::op_add, x, y);
        end
        report_test("add", 300);

        for (n = 0; n < 300; n++) begin
            rand_float(100, 55, x);
            rand_float(100, 55, y);
            if (n % 10 == 9) begin
                y = x;
            end
            run_op(fpu_op_pkg::op_sub, x, y);
        end
        report_test("sub", 300);

        for (n = 0; n < 300; n++) begin
            rand_float(100, 55, x);
            rand_float(100, 55, y);
            if (n % 10 == 4) begin
                x.f.exponent = '0;
            end else if (n % 10 == 9) begin
                y.f.exponent = '0;
            end
            run_op(fpu_op_pkg::op_mul, x, y);
        end
        report_test("mul", 300);

        x.i = 0;
        run_op(fpu_op_pkg::op_itof, x, x);
        x.i = -1;
        run_op(fpu_op_pkg::op_itof, x, x);
        x.i = -8388608;
        run_op(fpu_op_pkg::op_itof, x, x);
        x.i = -1073741823;
        run_op(fpu_op_pkg::op_itof, x, x);
        for (n = 0; n < 200; n++) begin
            rand_int(x);
            run_op(fpu_op_pkg::op_itof, x, x);
        end
        report_test("itof", 204);

        for (n = 0; n < 200; n++) begin
            rand_float(100, 57, x);  // exponent stays below 157
            run_op(fpu_op_pkg::op_ftoi, x, x);
        end
        report_test("ftoi", 200);

        // second start lands while the multiply is still running
        for (n = 0; n < 20; n++) begin
            rand_float(100, 55, x);
            rand_float(100, 55, y);
            @(negedge clk);
            start = 1'b1;
            op = fpu_op_pkg::op_mul;
            a = x;
            b = y;
            @(negedge clk);
            start = 1'b0;
            @(negedge clk);
            start = 1'b1;
            op = fpu_op_pkg::op_add;
            a = y;
            b = x;
            @(negedge clk);
            start = 1'b0;
            wait_done();
        end
        report_test("busy_start", 20);

        for (n = 5; n < 8; n++) begin
            rand_float(100, 55, x);
            @(negedge clk);
            start = 1'b1;
            op = fpu_op_pkg::op_width'(n);
            a = x;
            b = x;
            @(negedge clk);
            start = 1'b0;
            repeat (10) @(negedge clk);
        end
        run_op(fpu_op_pkg::op_add, x, x);
        report_test("reserved_op", 4);

        $display("closing: %0d results checked, %0d errors, %0d timeouts",
                 check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/fp_format_pkg.sv
source/fpu_op_pkg.sv
source/fp_addsub.sv
source/digit_multiplier.sv
source/fp_mul.sv
source/fp_convert.sv
source/fp_unit.sv
tb/fp_checker.sv
tb/tb_fp_unit.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the log

verilator --binary --timing -Wno-fatal --top-module tb_fp_unit -f sources.f \
    -o sim_fp_unit > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_fp_unit > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
